//--- all.f
hw/mem_access_pkg.sv
hw/ls_ifs.sv
hw/ls_decode.sv
hw/ls_lane_align.sv
hw/ls_bus_ctrl.sv
hw/ls_writeback.sv
hw/mem_access_unit.sv
verification/mem_access_chk.sv
verification/tb_mem_access_unit.sv

//--- hw/ls_bus_ctrl.sv
`timescale 1ns/10ps

module ls_bus_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    ls_req_if.ctrl                   req,
    ls_wb_if.src                     wb,
    output mem_access_pkg::word_t    mem_address,
    output logic                     mem_read,
    output logic                     mem_write,
    output mem_access_pkg::byte_en_t mem_byteenable,
    output mem_access_pkg::word_t    mem_writedata,
    input  mem_access_pkg::word_t    mem_readdata,
    input  logic                     waitrequest,
    output logic                     busy
);

    mem_access_pkg::ls_state_t state;
    mem_access_pkg::opcode_t   op_q;
    mem_access_pkg::reg_idx_t  rt_q;
    mem_access_pkg::word_t     addr_q;
    mem_access_pkg::word_t     rt_data_q;
    mem_access_pkg::word_t     result_q;
    mem_access_pkg::word_t     eff_addr;
    mem_access_pkg::word_t     load_data;
    logic                      write_q;
    logic                      take;
    logic                      complete;

    function automatic logic is_load(input mem_access_pkg::opcode_t op);
        return op inside {mem_access_pkg::OP_LB, mem_access_pkg::OP_LH,
                          mem_access_pkg::OP_LWL, mem_access_pkg::OP_LW,
                          mem_access_pkg::OP_LBU, mem_access_pkg::OP_LHU,
                          mem_access_pkg::OP_LWR};
    endfunction

    function automatic logic is_store(input mem_access_pkg::opcode_t op);
        return op inside {mem_access_pkg::OP_SB, mem_access_pkg::OP_SH,
                          mem_access_pkg::OP_SW};
    endfunction

    assign req.ready = (state == mem_access_pkg::IDLE);
    assign take      = req.valid && req.ready;
    assign complete  = (state == mem_access_pkg::ACCESS) && !waitrequest;
    assign eff_addr  = req.base + {{16{req.offset[15]}}, req.offset};  // Base + sext(offset)
    assign busy      = req.valid || (state != mem_access_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_access_pkg::IDLE;
        end else begin
            case (state)
                mem_access_pkg::IDLE: begin
                    if (take) begin
                        state <= (is_load(req.op) || is_store(req.op)) ?
                                 mem_access_pkg::ACCESS : mem_access_pkg::FINISH;
                    end
                end
                mem_access_pkg::ACCESS: begin
                    if (!waitrequest) begin
                        state <= mem_access_pkg::FINISH;
                    end
                end
                default: state <= mem_access_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q      <= req.op;
            rt_q      <= req.rt;
            addr_q    <= eff_addr;
            rt_data_q <= req.rt_data;
            write_q   <= is_load(req.op) || (req.op == mem_access_pkg::OP_LUI);
            result_q  <= {req.offset, 16'h0000};  // LUI result, replaced by loads
        end else if (complete) begin
            result_q  <= load_data;  // Readdata valid in this cycle
        end
    end

    ls_lane_align u_ls_lane_align (
        .op           (op_q),
        .addr_low     (addr_q[1:0]),
        .rt_data      (rt_data_q),
        .mem_readdata (mem_readdata),
        .byteenable   (mem_byteenable),
        .store_data   (mem_writedata),
        .load_data    (load_data)
    );

    // Registered sources keep the request steady through waitrequest
    assign mem_address = {addr_q[31:2], 2'b00};
    assign mem_read    = (state == mem_access_pkg::ACCESS) && is_load(op_q);
    assign mem_write   = (state == mem_access_pkg::ACCESS) && is_store(op_q);

    assign wb.finish = (state == mem_access_pkg::FINISH);
    assign wb.write  = write_q;
    assign wb.rt     = rt_q;
    assign wb.data   = result_q;

endmodule

//--- hw/ls_decode.sv
`timescale 1ns/10ps

module ls_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  mem_access_pkg::word_t instr,
    input  mem_access_pkg::word_t rs_data,
    input  mem_access_pkg::word_t rt_data,
    ls_req_if.decode              req
);

    logic load;
    logic taken;

    // A start is only accepted with nothing pending and the controller idle
    assign load  = start && !req.valid && req.ready;
    assign taken = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else if (load) begin
            req.valid <= 1'b1;
        end else if (taken) begin
            req.valid <= 1'b0;  // Controller has it now
        end
    end

    // Fields held until the controller takes them
    always_ff @(posedge clk) begin
        if (load) begin
            req.op      <= instr[31:26];
            req.rt      <= instr[20:16];
            req.offset  <= instr[15:0];
            req.base    <= rs_data;  // Register named by instr[25:21]
            req.rt_data <= rt_data;
        end
    end

endmodule

//--- hw/ls_ifs.sv
`timescale 1ns/10ps

interface ls_req_if;
    logic                     valid;
    logic                     ready;
    mem_access_pkg::opcode_t  op;
    mem_access_pkg::reg_idx_t rt;
    mem_access_pkg::imm_t     offset;
    mem_access_pkg::word_t    base;     // rs value
    mem_access_pkg::word_t    rt_data;  // Store data or merge source

    modport decode (output valid, op, rt, offset, base, rt_data, input ready);
    modport ctrl   (input valid, op, rt, offset, base, rt_data, output ready);
endinterface

interface ls_wb_if;
    logic                     finish;  // One-cycle completion strobe
    logic                     write;   // Strobe carries a register write
    mem_access_pkg::reg_idx_t rt;
    mem_access_pkg::word_t    data;

    modport src (output finish, write, rt, data);
    modport dst (input finish, write, rt, data);
endinterface

//--- hw/ls_lane_align.sv
`timescale 1ns/10ps

module ls_lane_align (
    input  mem_access_pkg::opcode_t  op,
    input  logic [1:0]               addr_low,
    input  mem_access_pkg::word_t    rt_data,
    input  mem_access_pkg::word_t    mem_readdata,
    output mem_access_pkg::byte_en_t byteenable,
    output mem_access_pkg::word_t    store_data,
    output mem_access_pkg::word_t    load_data
);

    logic [4:0]            byte_shift;   // 8 * lane
    logic [4:0]            half_shift;   // 16 * a[1]
    logic [4:0]            left_shift;   // 8 * (3 - lane)
    mem_access_pkg::word_t byte_lane;
    mem_access_pkg::word_t half_lane;
    mem_access_pkg::word_t lwl_data;
    mem_access_pkg::word_t lwr_data;

    assign byte_shift = {addr_low, 3'b000};
    assign half_shift = {addr_low[1], 4'b0000};
    assign left_shift = {~addr_low, 3'b000};  // 3 - a for a 2-bit lane

    assign byte_lane = mem_readdata >> byte_shift;
    assign half_lane = mem_readdata >> half_shift;

    // Memory bytes shifted up, rt keeps the bytes below
    assign lwl_data = (mem_readdata << left_shift) | (rt_data & ~(32'hFFFF_FFFF << left_shift));
    // Memory bytes shifted down, rt keeps the bytes above
    assign lwr_data = (mem_readdata >> byte_shift) | (rt_data & ~(32'hFFFF_FFFF >> byte_shift));

    always_comb begin
        byteenable = 4'b0000;
        store_data = rt_data;
        load_data  = mem_readdata;
        case (op)
            mem_access_pkg::OP_LB, mem_access_pkg::OP_LBU, mem_access_pkg::OP_SB: begin
                byteenable = 4'b0001 << addr_low;
                store_data = rt_data << byte_shift;
                if (op == mem_access_pkg::OP_LB) begin
                    load_data = {{24{byte_lane[7]}}, byte_lane[7:0]};
                end else begin
                    load_data = {24'h000000, byte_lane[7:0]};
                end
            end
            mem_access_pkg::OP_LH, mem_access_pkg::OP_LHU, mem_access_pkg::OP_SH: begin
                byteenable = addr_low[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
                store_data = rt_data << half_shift;
                if (op == mem_access_pkg::OP_LH) begin
                    load_data = {{16{half_lane[15]}}, half_lane[15:0]};
                end else begin
                    load_data = {16'h0000, half_lane[15:0]};
                end
            end
            mem_access_pkg::OP_LW, mem_access_pkg::OP_SW: begin
                byteenable = 4'b1111;
            end
            mem_access_pkg::OP_LWL: begin
                byteenable = 4'b1111 >> ~addr_low;  // Lanes 0 to a
                load_data  = lwl_data;
            end
            mem_access_pkg::OP_LWR: begin
                byteenable = 4'b1111 << addr_low;   // Lanes a to 3
                load_data  = lwr_data;
            end
            default: begin
                byteenable = 4'b0000;  // LUI and unknown opcodes
            end
        endcase
    end

endmodule

//--- hw/ls_writeback.sv
`timescale 1ns/10ps

module ls_writeback (
    input  logic                     clk,
    input  logic                     rst,
    ls_wb_if.dst                     wb,
    output logic                     reg_write,
    output mem_access_pkg::reg_idx_t reg_addr,
    output mem_access_pkg::word_t    reg_wdata,
    output logic                     done
);

    logic write_now;

    assign write_now = wb.finish && wb.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            done      <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            done      <= wb.finish;  // One cycle, follows the strobe
            reg_write <= write_now;
        end
    end

    // Held from the last register write
    always_ff @(posedge clk) begin
        if (write_now) begin
            reg_addr  <= wb.rt;
            reg_wdata <= wb.data;
        end
    end

endmodule

//--- hw/mem_access_pkg.sv
package mem_access_pkg;

    typedef logic [31:0] word_t;     // Data word or byte address
    typedef logic [4:0]  reg_idx_t;  // Register file index
    typedef logic [3:0]  byte_en_t;  // Lane 0 is bits 7:0
    typedef logic [5:0]  opcode_t;   // Instruction bits 31:26
    typedef logic [15:0] imm_t;      // Instruction bits 15:0

    // Loads
    localparam opcode_t OP_LB  = 6'h20;
    localparam opcode_t OP_LH  = 6'h21;
    localparam opcode_t OP_LWL = 6'h22;
    localparam opcode_t OP_LW  = 6'h23;
    localparam opcode_t OP_LBU = 6'h24;
    localparam opcode_t OP_LHU = 6'h25;
    localparam opcode_t OP_LWR = 6'h26;

    // Stores
    localparam opcode_t OP_SB  = 6'h28;
    localparam opcode_t OP_SH  = 6'h29;
    localparam opcode_t OP_SW  = 6'h2B;

    // Immediate only, never touches the bus
    localparam opcode_t OP_LUI = 6'h0F;

    typedef enum logic [1:0] {
        IDLE,    // Waiting for a request
        ACCESS,  // Bus request outstanding
        FINISH   // Result ready for write-back
    } ls_state_t;

endpackage

//--- hw/mem_access_unit.sv
`timescale 1ns/10ps

module mem_access_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  mem_access_pkg::word_t    instr,
    input  mem_access_pkg::word_t    rs_data,
    input  mem_access_pkg::word_t    rt_data,
    output logic                     busy,
    output logic                     reg_write,
    output mem_access_pkg::reg_idx_t reg_addr,
    output mem_access_pkg::word_t    reg_wdata,
    output logic                     done,
    output mem_access_pkg::word_t    mem_address,
    output logic                     mem_read,
    output logic                     mem_write,
    output mem_access_pkg::byte_en_t mem_byteenable,
    output mem_access_pkg::word_t    mem_writedata,
    input  mem_access_pkg::word_t    mem_readdata,
    input  logic                     waitrequest
);

    ls_req_if req_bus ();  // Decode to controller
    ls_wb_if  wb_bus ();   // Controller to write-back

    ls_decode u_ls_decode (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .req     (req_bus.decode)
    );

    ls_bus_ctrl u_ls_bus_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req            (req_bus.ctrl),
        .wb             (wb_bus.src),
        .mem_address    (mem_address),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_readdata   (mem_readdata),
        .waitrequest    (waitrequest),
        .busy           (busy)
    );

    ls_writeback u_ls_writeback (
        .clk       (clk),
        .rst       (rst),
        .wb        (wb_bus.dst),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .done      (done)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_access_unit \
    -f all.f

out=$(./obj_dir/Vtb_mem_access_unit)
echo "$out"

grep -qx "No errors" <<< "$out"

//--- verification/mem_access_chk.sv
`timescale 1ns/10ps

module mem_access_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     mem_read,
    input logic                     mem_write,
    input mem_access_pkg::word_t    mem_address,
    input mem_access_pkg::byte_en_t mem_byteenable,
    input mem_access_pkg::word_t    mem_writedata,
    input logic                     waitrequest,
    input logic                     done,
    input logic                     reg_write,
    input logic                     busy
);

    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write)) else $error("Read and write requested together");

    hold_on_wait: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) && waitrequest |=>
        $stable(mem_address) && $stable(mem_read) && $stable(mem_write) &&
        $stable(mem_byteenable) && $stable(mem_writedata))
        else $error("Request changed during waitrequest");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done) else $error("Done held longer than one cycle");

    write_with_done: assert property (@(posedge clk) disable iff (rst)
        reg_write |-> done) else $error("Register write without done");

    idle_at_done: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy) else $error("Busy still high at done");

endmodule

bind mem_access_unit mem_access_chk u_mem_access_chk (
    .clk            (clk),
    .rst            (rst),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .mem_address    (mem_address),
    .mem_byteenable (mem_byteenable),
    .mem_writedata  (mem_writedata),
    .waitrequest    (waitrequest),
    .done           (done),
    .reg_write      (reg_write),
    .busy           (busy)
);

//--- verification/tb_mem_access_unit.sv
`timescale 1ns/10ps

module tb_mem_access_unit;

    localparam int ROWS = 24;

    logic clk;
    logic rst;
    logic start;
    logic busy;
    logic reg_write;
    logic done;
    logic mem_read;
    logic mem_write;
    logic waitrequest;
    mem_access_pkg::word_t    instr;
    mem_access_pkg::word_t    rs_data;
    mem_access_pkg::word_t    rt_data;
    mem_access_pkg::reg_idx_t reg_addr;
    mem_access_pkg::word_t    reg_wdata;
    mem_access_pkg::word_t    mem_address;
    mem_access_pkg::byte_en_t mem_byteenable;
    mem_access_pkg::word_t    mem_writedata;
    mem_access_pkg::word_t    mem_readdata;

    mem_access_pkg::word_t mem [16];  // Memory model, indexed by address bits 5:2
    int stall_left;

    // Stimulus table
    mem_access_pkg::word_t    t_instr [ROWS];
    mem_access_pkg::word_t    t_rs    [ROWS];
    mem_access_pkg::word_t    t_rt    [ROWS];
    logic                     t_we    [ROWS];
    mem_access_pkg::reg_idx_t t_addr  [ROWS];
    mem_access_pkg::word_t    t_wdata [ROWS];
    logic [3:0]               t_idx   [ROWS];
    mem_access_pkg::word_t    t_mem   [ROWS];
    int                       t_lat   [ROWS];  // Edges from start to done, no stalls
    logic                     t_dbl   [ROWS];  // Pulse a second start while busy
    int n_rows;
    int errors;
    int failed;
    int tests;
    logic hung;  // A test never saw done

    mem_access_unit u_mem_access_unit (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign mem_readdata = mem[mem_address[5:2]];

    always @(posedge clk) begin
        if (mem_read || mem_write) begin
            if (waitrequest) begin
                stall_left  <= stall_left - 1;
                waitrequest <= (stall_left > 1);
            end else if (mem_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_byteenable[b]) begin
                        mem[mem_address[5:2]][8*b +: 8] <= mem_writedata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Every byte carries the word index in its upper nibble
    task automatic fill_memory();
        logic [3:0] n;
        for (int i = 0; i < 16; i++) begin
            n       = i[3:0];
            mem[i] <= {n, 4'h8, n, 4'h1, n, 4'hF, n, 4'h2};
        end
    endtask

    task automatic add_row(input mem_access_pkg::opcode_t op, input logic [15:0] imm,
                           input logic [31:0] base, input logic [31:0] rtv, input logic we,
                           input logic [31:0] wdata, input logic [3:0] idx,
                           input logic [31:0] emem, input int lat, input logic dbl);
        mem_access_pkg::reg_idx_t rt_idx;
        rt_idx           = 5'(n_rows + 1);
        t_instr[n_rows]  = {op, 5'd3, rt_idx, imm};
        t_rs[n_rows]     = base;
        t_rt[n_rows]     = rtv;
        t_we[n_rows]     = we;
        t_addr[n_rows]   = rt_idx;
        t_wdata[n_rows]  = wdata;
        t_idx[n_rows]    = idx;
        t_mem[n_rows]    = emem;
        t_lat[n_rows]    = lat;
        t_dbl[n_rows]    = dbl;
        n_rows           = n_rows + 1;
    endtask

    task automatic fill_table();
        add_row(6'h20, 16'hFFE4, 32'h140, 32'h0, 1, 32'hFFFFFF92, 9, 32'h98919F92, 4, 0);
        add_row(6'h20, 16'h0027, 32'h100, 32'h0, 1, 32'hFFFFFF98, 9, 32'h98919F92, 4, 0);
        add_row(6'h24, 16'h0025, 32'h100, 32'h0, 1, 32'h0000009F, 9, 32'h98919F92, 4, 0);
        add_row(6'h20, 16'h0006, 32'h100, 32'h0, 1, 32'h00000011, 1, 32'h18111F12, 4, 0);
        add_row(6'h21, 16'h0024, 32'h100, 32'h0, 1, 32'hFFFF9F92, 9, 32'h98919F92, 4, 0);
        add_row(6'h21, 16'h0026, 32'h100, 32'h0, 1, 32'hFFFF9891, 9, 32'h98919F92, 4, 0);
        add_row(6'h25, 16'h0026, 32'h100, 32'h0, 1, 32'h00009891, 9, 32'h98919F92, 4, 0);
        add_row(6'h21, 16'h0004, 32'h100, 32'h0, 1, 32'h00001F12, 1, 32'h18111F12, 4, 0);
        add_row(6'h23, 16'h0024, 32'h100, 32'h0, 1, 32'h98919F92, 9, 32'h98919F92, 4, 0);
        // LWL and LWR against word 1 with rt = AABBCCDD
        add_row(6'h22, 16'h0004, 32'h100, 32'hAABBCCDD, 1, 32'h12BBCCDD, 1, 32'h18111F12, 4, 0);
        add_row(6'h22, 16'h0005, 32'h100, 32'hAABBCCDD, 1, 32'h1F12CCDD, 1, 32'h18111F12, 4, 0);
        add_row(6'h22, 16'h0006, 32'h100, 32'hAABBCCDD, 1, 32'h111F12DD, 1, 32'h18111F12, 4, 0);
        add_row(6'h22, 16'h0007, 32'h100, 32'hAABBCCDD, 1, 32'h18111F12, 1, 32'h18111F12, 4, 0);
        add_row(6'h26, 16'h0004, 32'h100, 32'hAABBCCDD, 1, 32'h18111F12, 1, 32'h18111F12, 4, 0);
        add_row(6'h26, 16'h0005, 32'h100, 32'hAABBCCDD, 1, 32'hAA18111F, 1, 32'h18111F12, 4, 0);
        add_row(6'h26, 16'h0006, 32'h100, 32'hAABBCCDD, 1, 32'hAABB1811, 1, 32'h18111F12, 4, 0);
        add_row(6'h26, 16'h0007, 32'h100, 32'hAABBCCDD, 1, 32'hAABBCC18, 1, 32'h18111F12, 4, 0);
        // Stores, then read back the merged word
        add_row(6'h28, 16'h0015, 32'h100, 32'h000000C3, 0, 32'h0, 5, 32'h5851C352, 4, 0);
        add_row(6'h29, 16'h0016, 32'h100, 32'h00007E6D, 0, 32'h0, 5, 32'h7E6DC352, 4, 0);
        add_row(6'h23, 16'h0014, 32'h100, 32'h0, 1, 32'h7E6DC352, 5, 32'h7E6DC352, 4, 0);
        add_row(6'h2B, 16'h0030, 32'h100, 32'hDEADBEEF, 0, 32'h0, 12, 32'hDEADBEEF, 4, 0);
        add_row(6'h23, 16'h0030, 32'h100, 32'h0, 1, 32'hDEADBEEF, 12, 32'hDEADBEEF, 4, 1);
        add_row(6'h0F, 16'h1234, 32'h0, 32'h0, 1, 32'h12340000, 13, 32'hD8D1DFD2, 3, 0);
        add_row(6'h3F, 16'h0008, 32'h100, 32'h0, 0, 32'h0, 2, 32'h28212F22, 3, 0);
    endtask

    task automatic run_row(input int r, input int stalls);
        int k;
        int bus_cycles;
        int busy_low;
        int extra_done;
        int row_err;
        int exp_k;
        k          = 0;
        bus_cycles = 0;
        busy_low   = 0;
        extra_done = 0;
        row_err    = 0;
        @(posedge clk);
        stall_left  <= stalls;
        waitrequest <= (stalls != 0);
        instr       <= t_instr[r];
        rs_data     <= t_rs[r];
        rt_data     <= t_rt[r];
        start       <= 1'b1;
        do begin
            @(posedge clk);
            if (t_dbl[r] && k == 1) begin
                start   <= 1'b1;
                instr   <= {mem_access_pkg::OP_SW, 5'd3, 5'd9, 16'h0030};
                rt_data <= 32'h0;  // Would clear the word if accepted
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            k = k + 1;
            if (mem_read || mem_write) bus_cycles = bus_cycles + 1;
            if (!done && busy !== 1'b1) busy_low = busy_low + 1;
        end while (!done && k < 40);
        if (!done) begin
            $display("Timeout waiting for done on test %0d", r);
            errors++;
            hung = 1'b1;
        end else begin
            exp_k = (t_lat[r] == 4) ? 4 + stalls : 3;
            if (k != exp_k) begin
                $display("Mismatch done edge: got %h expected %h", k, exp_k);
                row_err++;
            end
            if (busy_low != 0) begin
                $display("Busy dropped before done on test %0d", r);
                row_err++;
            end
            if (reg_write !== t_we[r]) begin
                $display("Mismatch reg_write: got %h expected %h", reg_write, t_we[r]);
                row_err++;
            end
            if (t_we[r] && reg_addr !== t_addr[r]) begin
                $display("Mismatch reg_addr: got %h expected %h", reg_addr, t_addr[r]);
                row_err++;
            end
            if (t_we[r] && reg_wdata !== t_wdata[r]) begin
                $display("Mismatch reg_wdata: got %h expected %h", reg_wdata, t_wdata[r]);
                row_err++;
            end
            if (bus_cycles != ((t_lat[r] == 4) ? stalls + 1 : 0)) begin
                $display("Wrong number of bus cycles on test %0d: %0d", r, bus_cycles);
                row_err++;
            end
            if (t_dbl[r]) begin
                repeat (6) begin
                    @(negedge clk);
                    if (done) extra_done = extra_done + 1;
                end
                if (extra_done != 0) begin
                    $display("Second start while busy was not ignored");
                    row_err++;
                end
            end
            if (mem[t_idx[r]] !== t_mem[r]) begin
                $display("Mismatch mem[%0d]: got %h expected %h", t_idx[r], mem[t_idx[r]],
                         t_mem[r]);
                row_err++;
            end
            tests = tests + 1;
            if (row_err != 0) failed = failed + 1;
            errors = errors + row_err;
            $display("Test %0d stalls %0d: %s", r, stalls, (row_err == 0) ? "ok" : "failed");
        end
    endtask

    initial begin
        void'($urandom(32'hecc4));
        errors = 0;
        failed = 0;
        tests  = 0;
        n_rows = 0;
        hung   = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        instr       = 32'h0;
        rs_data     = 32'h0;
        rt_data     = 32'h0;
        waitrequest = 1'b0;
        stall_left  = 0;
        fill_memory();
        fill_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (done || reg_write || mem_read || mem_write || busy) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        for (int r = 0; r < ROWS && !hung; r++) run_row(r, 0);
        fill_memory();  // Stores expect the initial contents again
        for (int r = 0; r < ROWS && !hung; r++) begin
            run_row(r, (t_lat[r] == 4) ? int'($urandom % 4) : 0);
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
